//--- verilog.f
+incdir+sim
common/trdb_instr_pkg.sv
common/trdb_pkg.sv
encoder/trdb_instr_window.sv
encoder/trdb_branch_map.sv
encoder/trdb_priority.sv
src/trdb_packet_emitter.sv
src/trdb_encoder_top.sv
sim/trdb_tb_clock.sv
sim/trdb_tb.sv

//--- Bender.yml
package:
  name: trdb_encoder

sources:
  - common/trdb_instr_pkg.sv
  - common/trdb_pkg.sv
  - encoder/trdb_instr_window.sv
  - encoder/trdb_branch_map.sv
  - encoder/trdb_priority.sv
  - src/trdb_packet_emitter.sv
  - src/trdb_encoder_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/trdb_tb_clock.sv
      - sim/trdb_tb.sv

//--- sim/trdb_tb_tasks.svh
// Tasks of the trace encoder testbench
// Instruction driver, reference model of window, map and priority,
// compare tasks and the directed tests
`ifndef TRDB_TB_TASKS_SVH
`define TRDB_TB_TASKS_SVH

// Reference window, slot 0 is lc, 1 is tc, 2 is nc
trdb_instr_t  ref_slot [3];
int           ref_fill;
logic         ref_qual_seen;
// Packet already carried the branch of the current tc
logic         ref_tc_sent;
trdb_bmap_t   ref_map;
trdb_bcnt_t   ref_cnt;
trdb_packet_t exp_q [$];
trdb_iaddr_t  next_pc;
trdb_priv_t   cur_priv;

task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_packet(input trdb_packet_t act, input trdb_packet_t exp);
    if (act !== exp) begin
        $display("CHECK FAILED at %0t ns: packet differs from reference", $time);
        $display("  got      %s %s addr %h priv %0d bcnt %0d bmap %h",
                 act.format.name(), act.subformat.name(), act.iaddr, act.priv,
                 act.bcnt, act.bmap);
        $display("  expected %s %s addr %h priv %0d bcnt %0d bmap %h",
                 exp.format.name(), exp.subformat.name(), exp.iaddr, exp.priv,
                 exp.bcnt, exp.bmap);
        stop_on_error("Trace packet mismatch");
    end
endtask

task automatic check_ready(input logic act, input logic exp);
    if (act !== exp) begin
        $display("CHECK FAILED at %0t ns: instr_ready_o is %b, expected %b",
                 $time, act, exp);
        stop_on_error("Ready mismatch");
    end
endtask

// Applies the window, map and priority rules to one accepted instruction
function automatic void predict_packet(input trdb_instr_t rec);
    trdb_instr_t  lc, tc, nc;
    trdb_packet_t pkt;
    logic         first_qual;
    logic         req;
    // Leaving tc commits the outcome, unless a packet already took it
    if (ref_fill >= 2 && ref_slot[1].is_branch && !ref_tc_sent) begin
        ref_map[ref_cnt] = ref_slot[1].taken;
        ref_cnt          = ref_cnt + 5'd1;
    end
    ref_slot[0] = ref_slot[1];
    ref_slot[1] = ref_slot[2];
    ref_slot[2] = rec;
    ref_tc_sent = 1'b0;
    if (ref_fill < 3) begin
        ref_fill++;
    end
    // Decision only once all three slots hold an instruction
    if (ref_fill == 3) begin
        lc = ref_slot[0];
        tc = ref_slot[1];
        nc = ref_slot[2];
        pkt.iaddr     = tc.iaddr;
        pkt.priv      = tc.priv;
        pkt.bmap      = ref_map;
        pkt.bcnt      = ref_cnt;
        pkt.subformat = SF_UNDEF;
        pkt.format    = F_ADDR_ONLY;
        // tc's own branch travels with its packet
        if (tc.is_branch) begin
            pkt.bmap[ref_cnt] = tc.taken;
            pkt.bcnt          = ref_cnt + 5'd1;
        end
        first_qual = tc.qualified && (!lc.qualified || !ref_qual_seen);
        req        = 1'b1;
        if (lc.exception || first_qual || tc.priv != lc.priv) begin
            pkt.format    = F_SYNC;
            pkt.subformat = SF_START;
        end else if (lc.u_discontinuity || nc.exception || nc.priv != tc.priv) begin
            pkt.format = (pkt.bcnt == '0) ? F_ADDR_ONLY : F_BRANCH_FULL;
        end else if (pkt.bcnt == BRANCH_MAP_LEN) begin
            pkt.format = F_BRANCH_FULL;
        end else begin
            req = 1'b0;
        end
        if (tc.qualified) begin
            ref_qual_seen = 1'b1;
        end
        if (req) begin
            exp_q.push_back(pkt);
            ref_map     = '0;
            ref_cnt     = '0;
            ref_tc_sent = 1'b1;
        end
    end
endfunction

// Called at a rising edge, returns at the edge that accepts the instruction
task automatic retire(input logic exc, input logic br, input logic tk, input logic uj);
    trdb_instr_t rec;
    rec = '{iaddr: next_pc, priv: cur_priv, exception: exc, qualified: 1'b1,
            is_branch: br, taken: tk, u_discontinuity: uj};
    predict_packet(rec);
    next_pc = next_pc + 32'd4;
    #1;
    instr_valid = 1'b1;
    instr       = rec;
    @(negedge clk);
    while (!instr_ready) begin
        @(negedge clk);
    end
    @(posedge clk);
endtask

task automatic plain_instrs(input int n);
    repeat (n) begin
        retire(1'b0, 1'b0, 1'b0, 1'b0);
    end
endtask

task automatic reset_dut(input trdb_iaddr_t base);
    @(posedge clk);
    #1;
    reset       = 1'b1;
    instr_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset         = 1'b0;
    ref_fill      = 0;
    ref_qual_seen = 1'b0;
    ref_tc_sent   = 1'b0;
    ref_map       = '0;
    ref_cnt       = '0;
    exp_q.delete();
    next_pc       = base;
    cur_priv      = 2'b11;
    packets_seen  = 0;
    credit_owed   = 0;
    hold_credits  = 1'b0;
    @(posedge clk);
endtask

// Idles the input until every predicted packet was seen
task automatic drain_packets();
    int cycles;
    cycles = 0;
    #1;
    instr_valid = 1'b0;
    while (exp_q.size() != 0 && cycles < DRAIN_CYCLES) begin
        @(negedge clk);
        cycles++;
    end
    if (exp_q.size() != 0) begin
        stop_on_error("Predicted trace packet never appeared on the output");
    end
    // Room for a stray packet to show up
    repeat (6) @(negedge clk);
    @(posedge clk);
endtask

task automatic sync_after_reset();
    reset_dut(32'h8000_0000);
    @(negedge clk);
    check_ready(instr_ready, 1'b1);
    @(posedge clk);
    plain_instrs(4);
    drain_packets();
endtask

task automatic exception_packets();
    reset_dut(32'h8000_1000);
    plain_instrs(2);
    retire(1'b0, 1'b1, 1'b1, 1'b0);
    plain_instrs(1);
    // nc exception with a pending branch, then lc exception
    retire(1'b1, 1'b0, 1'b0, 1'b0);
    plain_instrs(3);
    // Same with an empty map
    retire(1'b1, 1'b0, 1'b0, 1'b0);
    plain_instrs(2);
    drain_packets();
endtask

task automatic privilege_change();
    reset_dut(32'h0001_0000);
    plain_instrs(3);
    // Drop to user mode
    cur_priv = 2'b00;
    plain_instrs(3);
    drain_packets();
endtask

task automatic full_branch_map();
    int rnd;
    reset_dut(32'h0002_0000);
    plain_instrs(2);
    repeat (BRANCH_MAP_LEN) begin
        rnd = $random(seed);
        retire(1'b0, 1'b1, rnd[0], 1'b0);
    end
    // Next branch must start again at index zero
    rnd = $random(seed);
    retire(1'b0, 1'b1, rnd[0], 1'b0);
    plain_instrs(1);
    retire(1'b1, 1'b0, 1'b0, 1'b0);
    plain_instrs(2);
    drain_packets();
endtask

task automatic uninferable_jump();
    reset_dut(32'h0003_0000);
    plain_instrs(2);
    retire(1'b0, 1'b0, 1'b0, 1'b1);
    plain_instrs(2);
    // Pending branch ahead of the jump
    retire(1'b0, 1'b1, 1'b1, 1'b0);
    retire(1'b0, 1'b0, 1'b0, 1'b1);
    plain_instrs(2);
    drain_packets();
endtask

task automatic credit_backpressure();
    reset_dut(32'h0000_4000);
    hold_credits = 1'b1;
    fork
        begin
            // Alternating privilege makes every decision a packet
            for (int i = 0; i < 10; i++) begin
                cur_priv = i[0] ? 2'b00 : 2'b11;
                retire(1'b0, 1'b0, 1'b0, 1'b0);
            end
        end
        begin
            wait (packets_seen == NUM_CREDITS);
            repeat (4) @(negedge clk);
            if (packets_seen != NUM_CREDITS) begin
                stop_on_error("More packets were sent than the sink had credits for");
            end
            check_ready(instr_ready, 1'b0);
            hold_credits = 1'b0;
        end
    join
    drain_packets();
endtask

`endif

//--- sim/trdb_tb.sv
// Testbench for the RISC-V trace encoder
// Retires instruction streams into the encoder, predicts the trace packets
// and checks them at a credit-controlled sink
`timescale 1ns/100ps
`default_nettype none

module trdb_tb;

    import trdb_pkg::*;
    import trdb_instr_pkg::*;

    // Instructions retired over all tests run back to back
    localparam int TOTAL_INSTR   = 78;
    localparam int CLK_PERIOD_NS = 8;
    localparam int WATCHDOG_NS   = TOTAL_INSTR * 50 * CLK_PERIOD_NS;
    // Upper bound on waiting for the last predicted packet
    localparam int DRAIN_CYCLES  = 40;

    logic         clk;
    logic         reset;
    logic         instr_valid;
    trdb_instr_t  instr;
    logic         instr_ready;
    logic         credit_return;
    logic         packet_valid;
    trdb_packet_t packet;

    // Sink side bookkeeping
    int           packets_seen;
    int           credit_owed;
    logic         hold_credits;
    int           seed;

    trdb_tb_clock u_trdb_tb_clock (
        .clk_o (clk)
    );

    trdb_encoder_top u_trdb_encoder_top (
        .clk_i           (clk),
        .reset_i         (reset),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .instr_ready_o   (instr_ready),
        .credit_return_i (credit_return),
        .packet_valid_o  (packet_valid),
        .packet_o        (packet)
    );

    `include "trdb_tb_tasks.svh"

    // Packet monitor samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (reset === 1'b0 && packet_valid === 1'b1) begin
            packets_seen++;
            credit_owed++;
            if (exp_q.size() == 0) begin
                stop_on_error("Encoder sent a packet the reference model did not predict");
            end else begin
                check_packet(packet, exp_q.pop_front());
            end
        end
    end

    // Sink frees one buffer entry per cycle unless it is told to hold
    always @(posedge clk) begin
        #1;
        if (!hold_credits && credit_owed > 0) begin
            credit_return = 1'b1;
            credit_owed--;
        end else begin
            credit_return = 1'b0;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_on_error("Watchdog expired before all tests finished");
    end

    initial begin
        seed          = 32184;
        reset         = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        credit_return = 1'b0;
        hold_credits  = 1'b0;
        packets_seen  = 0;
        credit_owed   = 0;

        sync_after_reset();
        exception_packets();
        privilege_change();
        full_branch_map();
        uninferable_jump();
        credit_backpressure();

        if (exp_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error("Predicted packets left over at the end of the run");
        end
    end

endmodule : trdb_tb

`default_nettype wire

//--- sim/trdb_tb_clock.sv
// Clock source for the trace encoder testbench
// Free-running clock with an 8 ns period
`timescale 1ns/100ps
`default_nettype none

module trdb_tb_clock (
    output logic clk_o
);

    // Half of the 8 ns period
    localparam int HALF_PERIOD_NS = 4;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk_o = ~clk_o;
        end
    end

endmodule : trdb_tb_clock

`default_nettype wire

//--- src/trdb_encoder_top.sv
// RISC-V instruction trace encoder
// Window, branch map, priority and emitter between the retire port
// and a credit-controlled packet sink
`timescale 1ns/100ps
`default_nettype none

module trdb_encoder_top (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        instr_valid_i,
    input  wire trdb_instr_pkg::trdb_instr_t instr_i,
    output logic                             instr_ready_o,
    input  wire logic                        credit_return_i,
    output logic                             packet_valid_o,
    output trdb_pkg::trdb_packet_t           packet_o
);

    import trdb_pkg::*;
    import trdb_instr_pkg::*;

    // Window outputs
    trdb_instr_t     tc_instr;
    logic            win_valid;
    logic            lc_exception, tc_first_qualified, tc_privchange;
    logic            lc_u_discontinuity, nc_exception, nc_privchange;
    // Branch map state
    trdb_bmap_t      bmap;
    trdb_bcnt_t      bcnt;
    logic            bmap_full, bmap_empty;
    // Decision and flow control
    logic            req_valid;
    trdb_format_t    packet_format;
    trdb_subformat_t packet_subformat;
    logic            stall, clear;
    // Accepted instruction, slots move on this edge
    logic            instr_shift;

    assign instr_shift = instr_valid_i & instr_ready_o;

    trdb_instr_window u_trdb_instr_window (
        .clk_i, .reset_i, .instr_valid_i, .instr_i,
        .stall_i              (stall),
        .instr_ready_o,
        .win_valid_o          (win_valid),
        .tc_instr_o           (tc_instr),
        .lc_exception_o       (lc_exception),
        .tc_first_qualified_o (tc_first_qualified),
        .tc_privchange_o      (tc_privchange),
        .lc_u_discontinuity_o (lc_u_discontinuity),
        .nc_exception_o       (nc_exception),
        .nc_privchange_o      (nc_privchange)
    );

    trdb_branch_map u_trdb_branch_map (
        .clk_i, .reset_i,
        .shift_i    (instr_shift),
        .tc_instr_i (tc_instr),
        .clear_i    (clear),
        .bmap_o     (bmap),
        .bcnt_o     (bcnt),
        .full_o     (bmap_full),
        .empty_o    (bmap_empty)
    );

    trdb_priority u_trdb_priority (
        .valid_i              (win_valid),
        .lc_exception_i       (lc_exception),
        .tc_first_qualified_i (tc_first_qualified),
        .tc_privchange_i      (tc_privchange),
        .lc_u_discontinuity_i (lc_u_discontinuity),
        .nc_exception_i       (nc_exception),
        .nc_privchange_i      (nc_privchange),
        .branch_map_full_i    (bmap_full),
        .branch_map_empty_i   (bmap_empty),
        .valid_o              (req_valid),
        .packet_format_o      (packet_format),
        .packet_subformat_o   (packet_subformat)
    );

    trdb_packet_emitter u_trdb_packet_emitter (
        .clk_i, .reset_i,
        .req_valid_i        (req_valid),
        .packet_format_i    (packet_format),
        .packet_subformat_i (packet_subformat),
        .tc_instr_i         (tc_instr),
        .bmap_i             (bmap),
        .bcnt_i             (bcnt),
        .credit_return_i,
        .stall_o            (stall),
        .clear_o            (clear),
        .packet_valid_o,
        .packet_o
    );

endmodule : trdb_encoder_top

`default_nettype wire

//--- src/trdb_packet_emitter.sv
// Trace packet emitter with credit-based flow control
// Registers one packet per granted request and stalls the window while
// a request waits for a sink credit
`timescale 1ns/100ps
`default_nettype none

module trdb_packet_emitter (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        req_valid_i,
    input  wire trdb_pkg::trdb_format_t      packet_format_i,
    input  wire trdb_pkg::trdb_subformat_t   packet_subformat_i,
    input  wire trdb_instr_pkg::trdb_instr_t tc_instr_i,
    input  wire trdb_pkg::trdb_bmap_t        bmap_i,
    input  wire trdb_pkg::trdb_bcnt_t        bcnt_i,
    input  wire logic                        credit_return_i,
    output logic                             stall_o,
    output logic                             clear_o,
    output logic                             packet_valid_o,
    output trdb_pkg::trdb_packet_t           packet_o
);

    import trdb_pkg::*;

    trdb_credit_t credits_q, credits_d;
    trdb_packet_t packet_q;
    logic         packet_valid_q;
    logic         credit_avail;
    logic         send;

    // A credit coming back this cycle can be used right away
    assign credit_avail = (credits_q != '0) | credit_return_i;
    assign send         = req_valid_i & credit_avail;

    // Hold the window until the sink has room
    assign stall_o = req_valid_i & ~credit_avail;
    // Map content is in this packet
    assign clear_o = send;

    always_comb begin
        credits_d = credits_q;
        if (credit_return_i) begin
            credits_d = credits_d + trdb_credit_t'(1);
        end
        // The credit is spent by the packet registered at this edge
        if (send) begin
            credits_d = credits_d - trdb_credit_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credits_q      <= trdb_credit_t'(NUM_CREDITS);
            packet_valid_q <= 1'b0;
        end else begin
            credits_q      <= credits_d;
            packet_valid_q <= send;
        end
    end

    // Packet payload is captured only on a granted request
    always_ff @(posedge clk_i) begin
        if (send) begin
            packet_q.format    <= packet_format_i;
            packet_q.subformat <= packet_subformat_i;
            packet_q.iaddr     <= tc_instr_i.iaddr;
            packet_q.priv      <= tc_instr_i.priv;
            packet_q.bcnt      <= bcnt_i;
            packet_q.bmap      <= bmap_i;
        end
    end

    assign packet_valid_o = packet_valid_q;
    assign packet_o       = packet_q;

    // Sink never returns more credits than its buffer holds
    assert property (@(posedge clk_i) disable iff (reset_i)
        credits_q <= trdb_credit_t'(NUM_CREDITS))
    else $error("credit count above sink depth");

endmodule : trdb_packet_emitter

`default_nettype wire

//--- encoder/trdb_priority.sv
// Packet request ordering for the trace encoder
// Picks format and subformat for tc from the window events and map state,
// first matching rule wins
`timescale 1ns/100ps
`default_nettype none

module trdb_priority (
    input  wire logic              valid_i,
    input  wire logic              lc_exception_i,
    input  wire logic              tc_first_qualified_i,
    input  wire logic              tc_privchange_i,
    input  wire logic              lc_u_discontinuity_i,
    input  wire logic              nc_exception_i,
    input  wire logic              nc_privchange_i,
    input  wire logic              branch_map_full_i,
    input  wire logic              branch_map_empty_i,
    output logic                   valid_o,
    output trdb_pkg::trdb_format_t    packet_format_o,
    output trdb_pkg::trdb_subformat_t packet_subformat_o
);

    import trdb_pkg::*;

    always_comb begin
        // Defaults leave no request pending
        valid_o            = 1'b0;
        packet_format_o    = F_ADDR_ONLY;
        packet_subformat_o = SF_UNDEF;

        if (valid_i) begin
            if (lc_exception_i) begin
                // Trap handler entry needs a full sync
                valid_o            = 1'b1;
                packet_format_o    = F_SYNC;
                packet_subformat_o = SF_START;
            end else if (tc_first_qualified_i || tc_privchange_i) begin
                valid_o            = 1'b1;
                packet_format_o    = F_SYNC;
                packet_subformat_o = SF_START;
            end else if (lc_u_discontinuity_i) begin
                // Target cannot be inferred, so send the address
                valid_o         = 1'b1;
                packet_format_o = branch_map_empty_i ? F_ADDR_ONLY : F_BRANCH_FULL;
            end else if (nc_exception_i || nc_privchange_i) begin
                // Flush tc before the next instruction changes context
                valid_o         = 1'b1;
                packet_format_o = branch_map_empty_i ? F_ADDR_ONLY : F_BRANCH_FULL;
            end else if (branch_map_full_i) begin
                valid_o         = 1'b1;
                packet_format_o = F_BRANCH_FULL;
            end
        end
    end

    // Window flags and map state must be resolved whenever a decision is made
    always_comb begin
        if (valid_i) begin
            assert final (!$isunknown({lc_exception_i, tc_first_qualified_i,
                                       tc_privchange_i, lc_u_discontinuity_i,
                                       nc_exception_i, nc_privchange_i,
                                       branch_map_full_i, branch_map_empty_i}))
            else $error("unknown priority input while valid");
        end
    end

endmodule : trdb_priority

`default_nettype wire

//--- encoder/trdb_branch_map.sv
// Branch outcome map for the trace encoder
// Collects taken/not-taken bits; tc's own branch shows up while it sits in tc
// and is committed when tc leaves, unless a packet already carried it
`timescale 1ns/100ps
`default_nettype none

module trdb_branch_map (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        shift_i,
    input  wire trdb_instr_pkg::trdb_instr_t tc_instr_i,
    input  wire logic                        clear_i,
    output trdb_pkg::trdb_bmap_t             bmap_o,
    output trdb_pkg::trdb_bcnt_t             bcnt_o,
    output logic                             full_o,
    output logic                             empty_o
);

    import trdb_pkg::*;

    // Committed outcomes of instructions that already left tc
    trdb_bmap_t map_q;
    trdb_bcnt_t cnt_q;
    // Current tc was reported by a packet that stayed in tc
    logic       sent_q;
    logic       pend;

    assign pend = tc_instr_i.is_branch & ~sent_q;

    // Map as seen by the priority and the emitter, tc included
    always_comb begin
        bmap_o = map_q;
        if (pend) begin
            bmap_o[cnt_q] = tc_instr_i.taken;
        end
    end

    assign bcnt_o  = cnt_q + trdb_bcnt_t'(pend);
    assign full_o  = (bcnt_o == trdb_bcnt_t'(BRANCH_MAP_LEN));
    assign empty_o = (bcnt_o == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            map_q  <= '0;
            cnt_q  <= '0;
            sent_q <= 1'b0;
        end else begin
            if (clear_i) begin
                // Everything up to and including tc went out in the packet
                map_q <= '0;
                cnt_q <= '0;
            end else if (shift_i && pend) begin
                map_q[cnt_q] <= tc_instr_i.taken;
                cnt_q        <= cnt_q + trdb_bcnt_t'(1);
            end
            // New tc arriving gets its bit counted from the next cycle on
            if (shift_i) begin
                sent_q <= 1'b0;
            end else if (clear_i) begin
                sent_q <= 1'b1;
            end
        end
    end

    // Full map must be drained before another branch reaches tc
    assert property (@(posedge clk_i) disable iff (reset_i)
        shift_i && full_o && !clear_i |=> !tc_instr_i.is_branch)
    else $error("branch map overflow");

endmodule : trdb_branch_map

`default_nettype wire

//--- encoder/trdb_instr_window.sv
// Three-slot window over the retired instruction stream
// Shifts records through nc, tc and lc and derives the event flags
// that drive packet selection for the instruction in tc
`timescale 1ns/100ps
`default_nettype none

module trdb_instr_window (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        instr_valid_i,
    input  wire trdb_instr_pkg::trdb_instr_t instr_i,
    input  wire logic                        stall_i,
    output logic                             instr_ready_o,
    output logic                             win_valid_o,
    output trdb_instr_pkg::trdb_instr_t      tc_instr_o,
    output logic                             lc_exception_o,
    output logic                             tc_first_qualified_o,
    output logic                             tc_privchange_o,
    output logic                             lc_u_discontinuity_o,
    output logic                             nc_exception_o,
    output logic                             nc_privchange_o
);

    import trdb_instr_pkg::*;

    // Slot payloads are only meaningful while the matching valid bit is set
    trdb_instr_t nc_q, tc_q, lc_q;
    logic        nc_v_q, tc_v_q, lc_v_q;
    logic        win_valid_q;
    // A qualified tc has already been decided on since reset
    logic        qual_seen_q;
    logic        shift;

    // Back-pressure from the emitter holds the core
    assign instr_ready_o = ~stall_i;
    assign shift         = instr_valid_i & instr_ready_o;

    // Payload moves one slot per accepted instruction
    always_ff @(posedge clk_i) begin
        if (shift) begin
            nc_q <= instr_i;
            tc_q <= nc_q;
            lc_q <= tc_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            nc_v_q      <= 1'b0;
            tc_v_q      <= 1'b0;
            lc_v_q      <= 1'b0;
            win_valid_q <= 1'b0;
            qual_seen_q <= 1'b0;
        end else begin
            if (shift) begin
                nc_v_q <= 1'b1;
                tc_v_q <= nc_v_q;
                lc_v_q <= tc_v_q;
            end
            // Decision stays frozen while the emitter stalls
            if (!stall_i) begin
                // Window is full after this shift when nc and tc were already valid
                win_valid_q <= shift & nc_v_q & tc_v_q;
            end
            if (win_valid_q && !stall_i && tc_q.qualified) begin
                qual_seen_q <= 1'b1;
            end
        end
    end

    assign win_valid_o = win_valid_q;

    // Empty tc reads as all zero, so no stale branch reaches the map
    assign tc_instr_o = tc_v_q ? tc_q : '0;

    // Event flags gated by the slots they look at
    assign lc_exception_o       = lc_v_q & lc_q.exception;
    assign lc_u_discontinuity_o = lc_v_q & lc_q.u_discontinuity;
    assign nc_exception_o       = nc_v_q & nc_q.exception;

    // First qualified tc after reset, or tracing just became qualified
    assign tc_first_qualified_o = tc_v_q & tc_q.qualified &
                                  (~lc_v_q | ~lc_q.qualified | ~qual_seen_q);

    assign tc_privchange_o = tc_v_q & lc_v_q & (tc_q.priv != lc_q.priv);
    assign nc_privchange_o = nc_v_q & tc_v_q & (nc_q.priv != tc_q.priv);

endmodule : trdb_instr_window

`default_nettype wire

//--- common/trdb_pkg.sv
// Trace packet definitions for the encoder
// Packet formats, subformats, branch map types and the packet record
`default_nettype none

package trdb_pkg;

    // Branch map holds up to this many outcomes
    localparam int BRANCH_MAP_LEN = 31;

    // Depth of the sink buffer, one credit per entry
    localparam int NUM_CREDITS = 4;
    localparam int CREDIT_W    = $clog2(NUM_CREDITS + 1);

    // Encodings follow the RISC-V trace format
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'h0,
        F_BRANCH_DIFF = 2'h1,
        F_ADDR_ONLY   = 2'h2,
        F_SYNC        = 2'h3
    } trdb_format_t;

    // Only meaningful for F_SYNC packets
    typedef enum logic [1:0] {
        SF_START     = 2'h0,
        SF_EXCEPTION = 2'h1,
        SF_CONTEXT   = 2'h2,
        SF_UNDEF     = 2'h3
    } trdb_subformat_t;

    typedef logic [BRANCH_MAP_LEN-1:0] trdb_bmap_t;
    typedef logic [4:0]                trdb_bcnt_t;
    typedef logic [CREDIT_W-1:0]       trdb_credit_t;

    // One trace packet as handed to the sink
    typedef struct packed {
        trdb_format_t              format;
        trdb_subformat_t           subformat;
        trdb_instr_pkg::trdb_iaddr_t iaddr;
        trdb_instr_pkg::trdb_priv_t  priv;
        trdb_bcnt_t                bcnt;
        trdb_bmap_t                bmap;
    } trdb_packet_t;

endpackage : trdb_pkg

`default_nettype wire

//--- common/trdb_instr_pkg.sv
// Retired-instruction definitions shared by the trace encoder
// Address and privilege types plus the record of one retired instruction
`default_nettype none

package trdb_instr_pkg;

    // Instruction address as reported by the core
    typedef logic [31:0] trdb_iaddr_t;

    // RISC-V privilege level (U, S, reserved, M)
    typedef logic [1:0] trdb_priv_t;

    // One retired instruction, handed over per accepted handshake
    typedef struct packed {
        trdb_iaddr_t iaddr;
        trdb_priv_t  priv;
        // Instruction trapped
        logic        exception;
        // Inside the trace filter
        logic        qualified;
        // Conditional branch and its outcome
        logic        is_branch;
        logic        taken;
        // Jump whose target cannot be inferred from the program binary
        logic        u_discontinuity;
    } trdb_instr_t;

endpackage : trdb_instr_pkg

`default_nettype wire
